/* Bender.yml */
package:
  name: fb_video

sources:
  - files:
      - rtl/fb_pkg.sv
      - rtl/fb_mem.sv
      - rtl/fb_burst_reader.sv
      - rtl/fb_scanout.sv
      - rtl/fb_video.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_fb_video.sv

/* fb_video.f */
rtl/fb_pkg.sv
rtl/fb_mem.sv
rtl/fb_burst_reader.sv
rtl/fb_scanout.sv
rtl/fb_video.sv
test/tb_clock.sv
test/tb_fb_video.sv

/* rtl/fb_burst_reader.sv */
module fb_burst_reader (
  input  logic             clk,
  input  logic             rst_n,

  input  fb_pkg::h_count_t h_visible,
  input  fb_pkg::v_count_t v_visible,

  output logic             ar_valid,
  output fb_pkg::ar_chan_t ar,
  input  logic             ar_ready,

  input  logic             r_valid,
  input  fb_pkg::r_chan_t  r,
  output logic             r_ready,

  output logic             pix_valid,
  output fb_pkg::pixel_t   pix,
  input  logic             pix_ready
);
  import fb_pkg::*;

  reader_state_t state;
  reader_state_t state_next;

  logic [h_width+v_width-1:0] frame_pixels;
  logic [h_width+v_width-1:0] burst_total;
  logic [h_width+v_width-1:0] burst_cnt;
  logic [h_width+v_width-1:0] burst_cnt_next;

  axi_addr_t burst_addr;
  axi_addr_t burst_addr_next;

  logic      ar_valid_next;
  axi_addr_t ar_addr_next;

  logic      last_beat;

  // resolution is static outside of reset, so this settles long before use
  assign frame_pixels = h_visible * v_visible;
  assign burst_total  = frame_pixels >> $clog2(burst_len);

  // read beats go straight out as pixels
  assign pix_valid = r_valid;
  assign pix       = pixel_t'(r.data[$bits(pixel_t)-1:0]);
  assign r_ready   = pix_ready;

  assign last_beat = r_valid && r_ready && r.last;

  always_comb begin
    state_next      = state;
    ar_valid_next   = ar_valid && !ar_ready;
    ar_addr_next    = ar.addr;
    burst_cnt_next  = burst_cnt;
    burst_addr_next = burst_addr;

    case (state)
      burst_init: begin
        // memory is idle, launch the next burst
        if (ar_ready) begin
          state_next     = burst;
          ar_valid_next  = 1'b1;
          ar_addr_next   = burst_addr;
          burst_cnt_next = burst_cnt + 1'b1;
        end
      end

      burst: begin
        if (last_beat) begin
          state_next = burst_init;
          if (burst_cnt != burst_total) begin
            burst_addr_next = burst_addr + axi_addr_t'(burst_bytes);
          end else begin
            // end of frame, start over at the top
            burst_addr_next = '0;
            burst_cnt_next  = '0;
          end
        end
      end

      default: begin
        state_next = burst_init;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= burst_init;
      burst_cnt  <= '0;
      burst_addr <= '0;
      ar_valid   <= 1'b0;
    end else begin
      state      <= state_next;
      burst_cnt  <= burst_cnt_next;
      burst_addr <= burst_addr_next;
      ar_valid   <= ar_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    ar.addr <= ar_addr_next;
  end

endmodule

/* rtl/fb_mem.sv */
module fb_mem (
  input  logic             clk,
  input  logic             rst_n,

  // load port, only used while the reader is held in reset
  input  logic             wr_en,
  input  fb_pkg::mem_wr_t  wr,

  input  logic             ar_valid,
  input  fb_pkg::ar_chan_t ar,
  output logic             ar_ready,

  output logic             r_valid,
  output fb_pkg::r_chan_t  r,
  input  logic             r_ready
);
  import fb_pkg::*;

  axi_data_t mem [mem_words];

  logic       ar_hs;
  logic       r_hs;
  logic       rd_en;

  mem_index_t rd_index;
  mem_index_t rd_index_next;
  mem_index_t ram_index;
  axi_data_t  rd_data;

  // beat number within the burst
  logic [$clog2(burst_len)-1:0] beat;
  logic                         beat_last;

  // one burst at a time, so idle means no beat pending
  assign ar_ready = !r_valid;

  assign ar_hs = ar_valid && ar_ready;
  assign r_hs  = r_valid && r_ready;

  // counter is all ones on the final beat
  assign beat_last = &beat;

  // a new word is fetched on the address transfer and on every beat but the last
  assign rd_en = ar_hs || (r_hs && !beat_last);

  always_comb begin
    rd_index_next = rd_index;
    if (ar_hs) begin
      rd_index_next = mem_index_t'(ar.addr >> $clog2(word_bytes));
    end else if (r_hs) begin
      rd_index_next = rd_index + 1'b1;
    end
  end

  // single port: writes and reads share the one address
  assign ram_index = wr_en ? wr.index : rd_index_next;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[ram_index] <= wr.data;
    end else if (rd_en) begin
      rd_data <= mem[ram_index];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid  <= 1'b0;
      rd_index <= '0;
      beat     <= '0;
    end else begin
      rd_index <= rd_index_next;

      if (ar_hs) begin
        r_valid <= 1'b1;
        beat    <= '0;
      end else if (r_hs) begin
        beat <= beat + 1'b1;
        if (beat_last) begin
          r_valid <= 1'b0;
        end
      end
    end
  end

  assign r.data = rd_data;
  assign r.last = beat_last;

endmodule

/* rtl/fb_pkg.sv */
package fb_pkg;

  // widths
  localparam int color_width    = 4;
  localparam int axi_addr_width = 12;
  localparam int axi_data_width = 16;
  localparam int h_width        = 12;
  localparam int v_width        = 12;

  // burst geometry, burst_len must be a power of two
  localparam int burst_len   = 128;
  localparam int word_bytes  = axi_data_width / 8;
  localparam int burst_bytes = burst_len * word_bytes;
  localparam int mem_words   = 2048;

  typedef logic [color_width-1:0]       color_t;
  typedef logic [axi_addr_width-1:0]    axi_addr_t;
  typedef logic [axi_data_width-1:0]    axi_data_t;
  typedef logic [$clog2(mem_words)-1:0] mem_index_t;
  typedef logic [h_width-1:0]           h_count_t;
  typedef logic [v_width-1:0]           v_count_t;

  // red sits in the top bits of the 12 bit pixel
  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  typedef struct packed {
    axi_addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } r_chan_t;

  typedef struct packed {
    mem_index_t index;
    axi_data_t  data;
  } mem_wr_t;

  typedef struct packed {
    pixel_t   pix;
    h_count_t x;
    v_count_t y;
    logic     sol;
    logic     sof;
  } pix_out_t;

  typedef enum logic {
    burst_init,
    burst
  } reader_state_t;

endpackage

/* rtl/fb_scanout.sv */
module fb_scanout (
  input  logic             clk,
  input  logic             rst_n,

  input  fb_pkg::h_count_t h_visible,
  input  fb_pkg::v_count_t v_visible,

  input  logic             pix_valid,
  input  fb_pkg::pixel_t   pix,
  output logic             pix_ready,

  output logic             out_valid,
  output fb_pkg::pix_out_t out,
  input  logic             out_ready
);
  import fb_pkg::*;

  // coordinate of the next pixel to be accepted
  h_count_t x;
  v_count_t y;

  logic     accept;
  logic     x_last;
  logic     y_last;

  // empty register or a draining one can take a new pixel
  assign pix_ready = !out_valid || out_ready;
  assign accept    = pix_valid && pix_ready;

  assign x_last = (x == h_visible - 1'b1);
  assign y_last = (y == v_visible - 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      x         <= '0;
      y         <= '0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
        if (x_last) begin
          x <= '0;
          y <= y_last ? '0 : y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // payload only moves on accept, so it holds while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      out.pix <= pix;
      out.x   <= x;
      out.y   <= y;
      out.sol <= (x == '0);
      out.sof <= (x == '0) && (y == '0);
    end
  end

endmodule

/* rtl/fb_video.sv */
module fb_video (
  input  logic             clk,
  input  logic             rst_n,

  input  fb_pkg::h_count_t h_visible,
  input  fb_pkg::v_count_t v_visible,

  input  logic             wr_en,
  input  fb_pkg::mem_wr_t  wr,

  output logic             out_valid,
  output fb_pkg::pix_out_t out,
  input  logic             out_ready
);
  import fb_pkg::*;

  // read address channel
  logic     ar_valid;
  ar_chan_t ar;
  logic     ar_ready;

  // read data channel
  logic     r_valid;
  r_chan_t  r;
  logic     r_ready;

  // pixel stream into scanout
  logic     pix_valid;
  pixel_t   pix;
  logic     pix_ready;

  fb_mem i_fb_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr       (wr),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready)
  );

  fb_burst_reader i_fb_burst_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .h_visible (h_visible),
    .v_visible (v_visible),
    .ar_valid  (ar_valid),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r         (r),
    .r_ready   (r_ready),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready)
  );

  fb_scanout i_fb_scanout (
    .clk       (clk),
    .rst_n     (rst_n),
    .h_visible (h_visible),
    .v_visible (v_visible),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready),
    .out_valid (out_valid),
    .out       (out),
    .out_ready (out_ready)
  );

endmodule

/* test/fb_video_testdata.txt */
// words 0 to 5: h_visible, v_visible, ready mode (0 always ready, 1 random), run 1 then run 2
// from 0x100: frame words of run 1, from 0x200: frame words of run 2
@000
0010 0010 0000
0020 000c 0001
@100
a000 a001 a002 a003 a004 a005 a006 a007 a008 a009 a00a a00b a00c a00d a00e a00f
a010 a011 a012 a013 a014 a015 a016 a017 a018 a019 a01a a01b a01c a01d a01e a01f
a020 a021 a022 a023 a024 a025 a026 a027 a028 a029 a02a a02b a02c a02d a02e a02f
a030 a031 a032 a033 a034 a035 a036 a037 a038 a039 a03a a03b a03c a03d a03e a03f
a040 a041 a042 a043 a044 a045 a046 a047 a048 a049 a04a a04b a04c a04d a04e a04f
a050 a051 a052 a053 a054 a055 a056 a057 a058 a059 a05a a05b a05c a05d a05e a05f
a060 a061 a062 a063 a064 a065 a066 a067 a068 a069 a06a a06b a06c a06d a06e a06f
a070 a071 a072 a073 a074 a075 a076 a077 a078 a079 a07a a07b a07c a07d a07e a07f
a080 a081 a082 a083 a084 a085 a086 a087 a088 a089 a08a a08b a08c a08d a08e a08f
a090 a091 a092 a093 a094 a095 a096 a097 a098 a099 a09a a09b a09c a09d a09e a09f
a0a0 a0a1 a0a2 a0a3 a0a4 a0a5 a0a6 a0a7 a0a8 a0a9 a0aa a0ab a0ac a0ad a0ae a0af
a0b0 a0b1 a0b2 a0b3 a0b4 a0b5 a0b6 a0b7 a0b8 a0b9 a0ba a0bb a0bc a0bd a0be a0bf
a0c0 a0c1 a0c2 a0c3 a0c4 a0c5 a0c6 a0c7 a0c8 a0c9 a0ca a0cb a0cc a0cd a0ce a0cf
a0d0 a0d1 a0d2 a0d3 a0d4 a0d5 a0d6 a0d7 a0d8 a0d9 a0da a0db a0dc a0dd a0de a0df
a0e0 a0e1 a0e2 a0e3 a0e4 a0e5 a0e6 a0e7 a0e8 a0e9 a0ea a0eb a0ec a0ed a0ee a0ef
a0f0 a0f1 a0f2 a0f3 a0f4 a0f5 a0f6 a0f7 a0f8 a0f9 a0fa a0fb a0fc a0fd a0fe a0ff
@200
5800 5801 5802 5803 5804 5805 5806 5807 5808 5809 580a 580b 580c 580d 580e 580f
5810 5811 5812 5813 5814 5815 5816 5817 5818 5819 581a 581b 581c 581d 581e 581f
5820 5821 5822 5823 5824 5825 5826 5827 5828 5829 582a 582b 582c 582d 582e 582f
5830 5831 5832 5833 5834 5835 5836 5837 5838 5839 583a 583b 583c 583d 583e 583f
5840 5841 5842 5843 5844 5845 5846 5847 5848 5849 584a 584b 584c 584d 584e 584f
5850 5851 5852 5853 5854 5855 5856 5857 5858 5859 585a 585b 585c 585d 585e 585f
5860 5861 5862 5863 5864 5865 5866 5867 5868 5869 586a 586b 586c 586d 586e 586f
5870 5871 5872 5873 5874 5875 5876 5877 5878 5879 587a 587b 587c 587d 587e 587f
5880 5881 5882 5883 5884 5885 5886 5887 5888 5889 588a 588b 588c 588d 588e 588f
5890 5891 5892 5893 5894 5895 5896 5897 5898 5899 589a 589b 589c 589d 589e 589f
58a0 58a1 58a2 58a3 58a4 58a5 58a6 58a7 58a8 58a9 58aa 58ab 58ac 58ad 58ae 58af
58b0 58b1 58b2 58b3 58b4 58b5 58b6 58b7 58b8 58b9 58ba 58bb 58bc 58bd 58be 58bf
58c0 58c1 58c2 58c3 58c4 58c5 58c6 58c7 58c8 58c9 58ca 58cb 58cc 58cd 58ce 58cf
58d0 58d1 58d2 58d3 58d4 58d5 58d6 58d7 58d8 58d9 58da 58db 58dc 58dd 58de 58df
58e0 58e1 58e2 58e3 58e4 58e5 58e6 58e7 58e8 58e9 58ea 58eb 58ec 58ed 58ee 58ef
58f0 58f1 58f2 58f3 58f4 58f5 58f6 58f7 58f8 58f9 58fa 58fb 58fc 58fd 58fe 58ff
5900 5901 5902 5903 5904 5905 5906 5907 5908 5909 590a 590b 590c 590d 590e 590f
5910 5911 5912 5913 5914 5915 5916 5917 5918 5919 591a 591b 591c 591d 591e 591f
5920 5921 5922 5923 5924 5925 5926 5927 5928 5929 592a 592b 592c 592d 592e 592f
5930 5931 5932 5933 5934 5935 5936 5937 5938 5939 593a 593b 593c 593d 593e 593f
5940 5941 5942 5943 5944 5945 5946 5947 5948 5949 594a 594b 594c 594d 594e 594f
5950 5951 5952 5953 5954 5955 5956 5957 5958 5959 595a 595b 595c 595d 595e 595f
5960 5961 5962 5963 5964 5965 5966 5967 5968 5969 596a 596b 596c 596d 596e 596f
5970 5971 5972 5973 5974 5975 5976 5977 5978 5979 597a 597b 597c 597d 597e 597f

/* test/tb_clock.sv */
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule

/* test/tb_fb_video.sv */
module tb_fb_video;
  timeunit 1ns;
  timeprecision 100ps;
  import fb_pkg::*;

  localparam int data_depth = 'h380;
  localparam int run_base   = 'h100;
  localparam int idle_limit = 1000;

  logic     clk;
  logic     rst_n;
  h_count_t h_visible;
  v_count_t v_visible;
  logic     wr_en;
  mem_wr_t  wr;
  logic     out_valid;
  pix_out_t out;
  logic     out_ready;

  logic [15:0] tdata [data_depth];

  int seed;
  int checks;
  int errors;

  tb_clock i_tb_clock (
    .clk (clk)
  );

  fb_video i_fb_video (
    .clk       (clk),
    .rst_n     (rst_n),
    .h_visible (h_visible),
    .v_visible (v_visible),
    .wr_en     (wr_en),
    .wr        (wr),
    .out_valid (out_valid),
    .out       (out),
    .out_ready (out_ready)
  );

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // frame is loaded while reset is held and out_valid must stay low throughout
  task automatic reset_and_load(input int base, input int h, input int v);
    int n;
    @(negedge clk);
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    out_ready = 1'b1;
    h_visible = h_count_t'(h);
    v_visible = v_count_t'(v);
    repeat (2) begin
      @(negedge clk);
      check_value("out_valid in reset", out_valid, 0);
    end
    for (n = 0; n < h * v; n++) begin
      wr_en    = 1'b1;
      wr.index = mem_index_t'(n);
      wr.data  = tdata[base + n];
      @(negedge clk);
      check_value("out_valid in reset", out_valid, 0);
    end
    wr_en = 1'b0;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("out_valid after reset release", out_valid, 0);
  endtask

  // collects two full frames and samples at the falling edge where outputs are settled
  task automatic stream_and_check(input int run, input int base, input int h,
                                  input int v, input int mode);
    int       frame;
    int       total;
    int       got;
    int       idle;
    int       n;
    int       rnd;
    int       errors_before;
    logic     stalled;
    pix_out_t held;
    errors_before = errors;
    frame   = h * v;
    total   = 2 * frame;
    got     = 0;
    idle    = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < total && idle < idle_limit) begin
      if (stalled) begin
        check_value("out_valid while stalled", out_valid, 1);
        check_value("out while stalled", out, held);
      end
      // ready for the coming rising edge, where the transfer is decided
      if (mode != 0) begin
        rnd       = $random(seed);
        out_ready = rnd[0];
      end else begin
        out_ready = 1'b1;
      end
      if (out_valid && out_ready) begin
        n = got % frame;
        check_value("pixel", out.pix, tdata[base + n][11:0]);
        check_value("x", out.x, n % h);
        check_value("y", out.y, n / h);
        check_value("sol", out.sol, (n % h) == 0);
        check_value("sof", out.sof, n == 0);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      stalled = out_valid && !out_ready;
      held    = out;
      @(negedge clk);
    end
    if (got < total) begin
      errors++;
      $display("run %0d timed out waiting for output pixel %0d of %0d", run, got, total);
    end
    $display("run %0d: %0dx%0d, %0d pixels, %0d errors", run, h, v, got,
             errors - errors_before);
  endtask

  initial begin
    int run;
    int base;
    int h;
    int v;
    int mode;
    rst_n     = 1'b0;
    h_visible = '0;
    v_visible = '0;
    wr_en     = 1'b0;
    wr        = '0;
    out_ready = 1'b1;
    seed      = 43;
    checks    = 0;
    errors    = 0;
    $readmemh("test/fb_video_testdata.txt", tdata);
    if (tdata[0] === 'x) begin
      errors++;
      $display("the test data file could not be read");
    end else begin
      for (run = 0; run < 2; run++) begin
        h    = tdata[3 * run];
        v    = tdata[3 * run + 1];
        mode = tdata[3 * run + 2];
        base = run_base * (run + 1);
        reset_and_load(base, h, v);
        stream_and_check(run + 1, base, h, v, mode);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
